// ==== gbox_link.f ====
+incdir+verification
hdl/gbox_pkg.sv
hdl/stream_if.sv
hdl/skid_buffer.sv
hdl/word_deserializer.sv
hdl/word_serializer.sv
hdl/gbox_link.sv
verification/gbox_link_tb.sv

// ==== hdl/gbox_link.sv ====
`timescale 1ns/1ps

module gbox_link (
    input  logic                  clk,
    input  logic                  rst,

    input  gbox_pkg::narrow_word_t rx_data_i,
    input  logic                  rx_last_i,
    input  logic                  rx_val_i,
    output logic                  rx_rdy_o,

    output gbox_pkg::wide_word_t  rx_word_o,
    output logic                  rx_word_last_o,
    output logic                  rx_word_val_o,
    input  logic                  rx_word_rdy_i,

    input  gbox_pkg::wide_word_t  tx_word_i,
    input  logic                  tx_word_last_i,
    input  logic                  tx_word_val_i,
    output logic                  tx_word_rdy_o,

    output gbox_pkg::narrow_word_t tx_data_o,
    output logic                  tx_last_o,
    output logic                  tx_val_o,
    input  logic                  tx_rdy_i
);

    import gbox_pkg::*;

    // receive path, narrow beats in and wide words out
    stream_if #(.WIDTH(NARROW_W)) rx_link ();
    stream_if #(.WIDTH(NARROW_W)) rx_beats ();
    stream_if #(.WIDTH(WIDE_W))   rx_words ();

    // transmit path, wide words in and narrow beats out
    stream_if #(.WIDTH(WIDE_W))   tx_link ();
    stream_if #(.WIDTH(WIDE_W))   tx_words ();
    stream_if #(.WIDTH(NARROW_W)) tx_beats ();

    assign rx_link.data = rx_data_i;
    assign rx_link.last = rx_last_i;
    assign rx_link.val  = rx_val_i;
    assign rx_rdy_o     = rx_link.rdy;

    skid_buffer #(.WIDTH(NARROW_W)) rx_skid (
        .clk (clk),
        .rst (rst),
        .up  (rx_link.sink),
        .dn  (rx_beats.source)
    );

    word_deserializer word_deserializer (
        .clk (clk),
        .rst (rst),
        .in  (rx_beats.sink),
        .out (rx_words.source)
    );

    assign rx_word_o      = rx_words.data;
    assign rx_word_last_o = rx_words.last;
    assign rx_word_val_o  = rx_words.val;
    assign rx_words.rdy   = rx_word_rdy_i;

    assign tx_link.data  = tx_word_i;
    assign tx_link.last  = tx_word_last_i;
    assign tx_link.val   = tx_word_val_i;
    assign tx_word_rdy_o = tx_link.rdy;

    skid_buffer #(.WIDTH(WIDE_W)) tx_skid (
        .clk (clk),
        .rst (rst),
        .up  (tx_link.sink),
        .dn  (tx_words.source)
    );

    word_serializer word_serializer (
        .clk (clk),
        .rst (rst),
        .in  (tx_words.sink),
        .out (tx_beats.source)
    );

    assign tx_data_o    = tx_beats.data;
    assign tx_last_o    = tx_beats.last;
    assign tx_val_o     = tx_beats.val;
    assign tx_beats.rdy = tx_rdy_i;

endmodule

// ==== hdl/gbox_pkg.sv ====
package gbox_pkg;

    // width of one beat on the narrow link
    localparam int NARROW_W = 8;

    // width of one word on the wide side
    localparam int WIDE_W = 32;

    // number of link beats that make up one word
    localparam int RATIO = WIDE_W / NARROW_W;

    // enough bits to count the slices of one word
    localparam int IDX_W = $clog2(RATIO);

    // one beat as it travels over the link
    typedef logic [NARROW_W-1:0] narrow_word_t;

    // one full word, slice 0 in the low bits
    typedef logic [WIDE_W-1:0] wide_word_t;

    // position of a slice inside a word
    typedef logic [IDX_W-1:0] slice_idx_t;

endpackage

// ==== hdl/skid_buffer.sv ====
`timescale 1ns/1ps

module skid_buffer #(
    parameter int WIDTH = gbox_pkg::NARROW_W
) (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   up,
    stream_if.source dn
);

    logic [WIDTH-1:0] store_data;
    logic             store_last;
    logic             store_val;
    logic             store_val_nx;
    logic             rdy_q;
    logic             up_take;
    logic             store_load;

    // a word is taken from upstream only while the registered ready is high
    assign up_take = up.val & rdy_q;

    // a live word that downstream refuses has to be parked in the store
    assign store_load = ~store_val & up_take & ~dn.rdy;

    always_comb begin
        store_val_nx = store_val;
        if (store_val) begin
            if (dn.rdy) begin
                store_val_nx = 1'b0;
            end
        end else if (store_load) begin
            store_val_nx = 1'b1;
        end
    end

    // ready follows the store one cycle later, so it stays low out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            store_val <= 1'b0;
            rdy_q     <= 1'b0;
        end else begin
            store_val <= store_val_nx;
            rdy_q     <= ~store_val_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (store_load) begin
            store_data <= up.data;
            store_last <= up.last;
        end
    end

    assign up.rdy = rdy_q;

    // the stored word goes out before anything new from upstream
    assign dn.data = store_val ? store_data : up.data;
    assign dn.last = store_val ? store_last : up.last;
    assign dn.val  = store_val | up_take;

endmodule

// ==== hdl/stream_if.sv ====
`timescale 1ns/1ps

interface stream_if #(
    parameter int WIDTH = gbox_pkg::NARROW_W
);

    logic [WIDTH-1:0] data;
    logic             last;
    logic             val;
    logic             rdy;

    // the producer side drives the payload and the valid flag
    modport source (
        output data,
        output last,
        output val,
        input  rdy
    );

    // the consumer side only answers with ready
    modport sink (
        input  data,
        input  last,
        input  val,
        output rdy
    );

endinterface

// ==== hdl/word_deserializer.sv ====
`timescale 1ns/1ps

module word_deserializer (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in,
    stream_if.source out
);

    import gbox_pkg::*;

    wide_word_t   acc_q;
    narrow_word_t beat_data;
    slice_idx_t   fill_idx;
    logic         out_val_q;
    logic         out_last_q;
    logic         advance;
    logic         beat;
    logic         close;

    // the output register may be reloaded when empty or being drained
    assign advance = ~out_val_q | out.rdy;

    // beats are accepted straight against the output stage
    assign beat = in.val & advance;

    assign beat_data = in.data;

    // a word closes on its fourth slice, or early when the beat carries last
    assign close = (fill_idx == slice_idx_t'(RATIO - 1)) | in.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_idx <= '0;
        end else if (beat) begin
            if (close) begin
                fill_idx <= '0;
            end else begin
                fill_idx <= fill_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_val_q  <= 1'b0;
            out_last_q <= 1'b0;
        end else if (advance) begin
            out_val_q  <= beat & close;
            out_last_q <= beat & in.last;
        end
    end

    // slice 0 starts a new word, so the upper slices are cleared there
    always_ff @(posedge clk) begin
        if (beat) begin
            if (fill_idx == '0) begin
                acc_q <= wide_word_t'(beat_data);
            end else begin
                acc_q[fill_idx*NARROW_W +: NARROW_W] <= beat_data;
            end
        end
    end

    assign in.rdy   = advance;
    assign out.data = acc_q;
    assign out.last = out_last_q;
    assign out.val  = out_val_q;

endmodule

// ==== hdl/word_serializer.sv ====
`timescale 1ns/1ps

module word_serializer (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in,
    stream_if.source out
);

    import gbox_pkg::*;

    wide_word_t shift_q;
    slice_idx_t slice_cnt;
    logic       out_val_q;
    logic       word_last_q;
    logic       final_slice;
    logic       slice_done;
    logic       take;

    assign final_slice = (slice_cnt == slice_idx_t'(RATIO - 1));

    // the current slice leaves on this edge
    assign slice_done = out_val_q & out.rdy;

    // a new word may load while idle or as the last slice of the previous one leaves
    assign in.rdy = ~out_val_q | (out.rdy & final_slice);

    assign take = in.val & in.rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_val_q   <= 1'b0;
            slice_cnt   <= '0;
            word_last_q <= 1'b0;
        end else if (take) begin
            out_val_q   <= 1'b1;
            slice_cnt   <= '0;
            word_last_q <= in.last;
        end else if (slice_done) begin
            if (final_slice) begin
                out_val_q <= 1'b0;
            end else begin
                slice_cnt <= slice_cnt + 1'b1;
            end
        end
    end

    // slices leave from the low end of the shift register
    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= in.data;
        end else if (slice_done & ~final_slice) begin
            shift_q <= shift_q >> NARROW_W;
        end
    end

    assign out.data = shift_q[NARROW_W-1:0];
    assign out.val  = out_val_q;

    // last only marks the closing slice of a word that came in with last
    assign out.last = word_last_q & final_slice;

endmodule

// ==== verification/gbox_ref_model.svh ====
`ifndef GBOX_REF_MODEL_SVH
`define GBOX_REF_MODEL_SVH

// expected receive words and their last flags, oldest first
wide_word_t   exp_word_q[$];
logic         exp_word_last_q[$];

// expected transmit beats and their last flags, oldest first
narrow_word_t exp_beat_q[$];
logic         exp_beat_last_q[$];

// the receive word that is still being filled from beats
wide_word_t   part_word;
int           part_cnt;

function automatic void model_reset();
    exp_word_q.delete();
    exp_word_last_q.delete();
    exp_beat_q.delete();
    exp_beat_last_q.delete();
    part_word = '0;
    part_cnt  = 0;
endfunction

// beat k of a word lands in slice k, and last closes the word with zeros above
function automatic void model_rx_beat(narrow_word_t data, logic last);
    part_word = part_word | (wide_word_t'(data) << (part_cnt * NARROW_W));
    part_cnt++;
    if (part_cnt == RATIO || last) begin
        exp_word_q.push_back(part_word);
        exp_word_last_q.push_back(last);
        part_word = '0;
        part_cnt  = 0;
    end
endfunction

// a word leaves as RATIO beats, least significant slice first
function automatic void model_tx_word(wide_word_t data, logic last);
    for (int i = 0; i < RATIO; i++) begin
        exp_beat_q.push_back(narrow_word_t'(data >> (i * NARROW_W)));
        exp_beat_last_q.push_back(last && (i == RATIO - 1));
    end
endfunction

`endif

// ==== verification/gbox_link_tb.sv ====
`timescale 1ns/1ps

module gbox_link_tb;

    import gbox_pkg::*;

    localparam int RX_PKTS    = 60;
    localparam int TX_PKTS    = 40;
    localparam int ACCEPT_TMO = 500;
    localparam int RDY_TMO    = 10;
    localparam int DRAIN_TMO  = 2000;

    logic         clk;
    logic         rst;
    narrow_word_t rx_data_i;
    logic         rx_last_i;
    logic         rx_val_i;
    logic         rx_rdy_o;
    wide_word_t   rx_word_o;
    logic         rx_word_last_o;
    logic         rx_word_val_o;
    logic         rx_word_rdy_i;
    wide_word_t   tx_word_i;
    logic         tx_word_last_i;
    logic         tx_word_val_i;
    logic         tx_word_rdy_o;
    narrow_word_t tx_data_o;
    logic         tx_last_o;
    logic         tx_val_o;
    logic         tx_rdy_i;

    int           err_cnt = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           rx_words_seen = 0;
    int           tx_beats_seen = 0;
    logic         timed_out = 1'b0;

    // output values captured while a stall was seen, checked on the next cycle
    logic         rx_hold = 1'b0;
    wide_word_t   rx_hold_word;
    logic         rx_hold_last;
    logic         tx_hold = 1'b0;
    narrow_word_t tx_hold_data;
    logic         tx_hold_last;

    `include "gbox_ref_model.svh"

    gbox_link dut_i (
        .clk            (clk),
        .rst            (rst),
        .rx_data_i      (rx_data_i),
        .rx_last_i      (rx_last_i),
        .rx_val_i       (rx_val_i),
        .rx_rdy_o       (rx_rdy_o),
        .rx_word_o      (rx_word_o),
        .rx_word_last_o (rx_word_last_o),
        .rx_word_val_o  (rx_word_val_o),
        .rx_word_rdy_i  (rx_word_rdy_i),
        .tx_word_i      (tx_word_i),
        .tx_word_last_i (tx_word_last_i),
        .tx_word_val_i  (tx_word_val_i),
        .tx_word_rdy_o  (tx_word_rdy_o),
        .tx_data_o      (tx_data_o),
        .tx_last_o      (tx_last_o),
        .tx_val_o       (tx_val_o),
        .tx_rdy_i       (tx_rdy_i)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic report_mismatch(string sig, logic [WIDE_W-1:0] exp, logic [WIDE_W-1:0] act);
        $display("FAIL t=%0t %s expected %0h got %0h", $time, sig, exp, act);
        err_cnt++;
    endtask

    task automatic finish_test(string name, int errs_before);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_failed++;
        end
        $display("test %s finished with %0d errors", name, err_cnt - errs_before);
    endtask

    // both output readies change at random to create back-pressure
    task automatic toggle_ready();
        forever begin
            @(posedge clk);
            #1;
            rx_word_rdy_i = ($urandom_range(3) != 0);
            tx_rdy_i      = ($urandom_range(3) != 0);
        end
    endtask

    task automatic send_rx_packets(int npkts);
        int   len;
        int   waited;
        logic accepted;
        for (int p = 0; p < npkts && !timed_out; p++) begin
            len = $urandom_range(12, 1);
            for (int i = 0; i < len && !timed_out; i++) begin
                rx_val_i = 1'b0;
                repeat (($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0) begin
                    @(posedge clk);
                    #1;
                end
                rx_data_i = narrow_word_t'($urandom);
                rx_last_i = (i == len - 1);
                rx_val_i  = 1'b1;
                accepted  = 1'b0;
                waited    = 0;
                // the beat is taken on the edge that follows a high ready
                while (!accepted && waited < ACCEPT_TMO) begin
                    @(negedge clk);
                    accepted = rx_rdy_o;
                    waited++;
                    @(posedge clk);
                    #1;
                end
                if (!accepted) begin
                    $display("timeout: rx beat of packet %0d was never accepted", p);
                    timed_out = 1'b1;
                    err_cnt++;
                end
            end
        end
        rx_val_i = 1'b0;
    endtask

    task automatic send_tx_packets(int npkts);
        int   len;
        int   waited;
        logic accepted;
        for (int p = 0; p < npkts && !timed_out; p++) begin
            len = $urandom_range(12, 1);
            for (int i = 0; i < len && !timed_out; i++) begin
                tx_word_val_i = 1'b0;
                repeat (($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0) begin
                    @(posedge clk);
                    #1;
                end
                tx_word_i      = wide_word_t'($urandom);
                tx_word_last_i = (i == len - 1);
                tx_word_val_i  = 1'b1;
                accepted       = 1'b0;
                waited         = 0;
                while (!accepted && waited < ACCEPT_TMO) begin
                    @(negedge clk);
                    accepted = tx_word_rdy_o;
                    waited++;
                    @(posedge clk);
                    #1;
                end
                if (!accepted) begin
                    $display("timeout: tx word of packet %0d was never accepted", p);
                    timed_out = 1'b1;
                    err_cnt++;
                end
            end
        end
        tx_word_val_i = 1'b0;
    endtask

    task automatic check_rx_output();
        if (rx_word_val_o && rx_word_rdy_i) begin
            if (exp_word_q.size() == 0) begin
                $display("rx word %0h at %0t came out with no word expected", rx_word_o, $time);
                err_cnt++;
            end else begin
                if (rx_word_o !== exp_word_q[0]) begin
                    report_mismatch("rx_word_o", exp_word_q[0], rx_word_o);
                end
                if (rx_word_last_o !== exp_word_last_q[0]) begin
                    report_mismatch("rx_word_last_o", exp_word_last_q[0], rx_word_last_o);
                end
                void'(exp_word_q.pop_front());
                void'(exp_word_last_q.pop_front());
                rx_words_seen++;
            end
        end
        if (rx_hold && (!rx_word_val_o || rx_word_o !== rx_hold_word
                || rx_word_last_o !== rx_hold_last)) begin
            $display("rx word output changed at %0t while it was stalled", $time);
            err_cnt++;
        end
        rx_hold      = rx_word_val_o && !rx_word_rdy_i;
        rx_hold_word = rx_word_o;
        rx_hold_last = rx_word_last_o;
    endtask

    task automatic check_tx_output();
        if (tx_val_o && tx_rdy_i) begin
            if (exp_beat_q.size() == 0) begin
                $display("tx beat %0h at %0t came out with no beat expected", tx_data_o, $time);
                err_cnt++;
            end else begin
                if (tx_data_o !== exp_beat_q[0]) begin
                    report_mismatch("tx_data_o", exp_beat_q[0], tx_data_o);
                end
                if (tx_last_o !== exp_beat_last_q[0]) begin
                    report_mismatch("tx_last_o", exp_beat_last_q[0], tx_last_o);
                end
                void'(exp_beat_q.pop_front());
                void'(exp_beat_last_q.pop_front());
                tx_beats_seen++;
            end
        end
        if (tx_hold && (!tx_val_o || tx_data_o !== tx_hold_data || tx_last_o !== tx_hold_last)) begin
            $display("tx beat output changed at %0t while it was stalled", $time);
            err_cnt++;
        end
        tx_hold      = tx_val_o && !tx_rdy_i;
        tx_hold_data = tx_data_o;
        tx_hold_last = tx_last_o;
    endtask

    // inputs and outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (!rst) begin
            if (rx_val_i && rx_rdy_o) begin
                model_rx_beat(rx_data_i, rx_last_i);
            end
            if (tx_word_val_i && tx_word_rdy_o) begin
                model_tx_word(tx_word_i, tx_word_last_i);
            end
            check_rx_output();
            check_tx_output();
        end
    end

    initial begin
        int unsigned seed;
        int          errs_before;
        int          waited;
        seed = 32'h7fde1bc2;
        void'($urandom(seed));
        rst            = 1'b1;
        rx_data_i      = '0;
        rx_last_i      = 1'b0;
        rx_val_i       = 1'b0;
        rx_word_rdy_i  = 1'b0;
        tx_word_i      = '0;
        tx_word_last_i = 1'b0;
        tx_word_val_i  = 1'b0;
        tx_rdy_i       = 1'b0;
        model_reset();
        fork
            toggle_ready();
        join_none

        errs_before = err_cnt;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (rx_word_val_o !== 1'b0) report_mismatch("rx_word_val_o", 0, rx_word_val_o);
        if (tx_val_o !== 1'b0) report_mismatch("tx_val_o", 0, tx_val_o);
        if (rx_rdy_o !== 1'b0) report_mismatch("rx_rdy_o", 0, rx_rdy_o);
        if (tx_word_rdy_o !== 1'b0) report_mismatch("tx_word_rdy_o", 0, tx_word_rdy_o);
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (rx_word_val_o !== 1'b0) report_mismatch("rx_word_val_o", 0, rx_word_val_o);
        if (tx_val_o !== 1'b0) report_mismatch("tx_val_o", 0, tx_val_o);
        waited = 0;
        while (!(rx_rdy_o && tx_word_rdy_o) && waited < RDY_TMO) begin
            @(negedge clk);
            waited++;
        end
        if (!(rx_rdy_o && tx_word_rdy_o)) begin
            $display("timeout: input ready did not rise after reset");
            err_cnt++;
        end
        finish_test("reset", errs_before);

        errs_before = err_cnt;
        @(posedge clk);
        #1;
        fork
            send_rx_packets(RX_PKTS);
            send_tx_packets(TX_PKTS);
        join
        finish_test("traffic", errs_before);

        // both output streams must empty the expected queues
        errs_before = err_cnt;
        waited = 0;
        while ((exp_word_q.size() != 0 || exp_beat_q.size() != 0) && waited < DRAIN_TMO) begin
            @(posedge clk);
            waited++;
        end
        if (exp_word_q.size() != 0 || exp_beat_q.size() != 0) begin
            $display("timeout: %0d rx words and %0d tx beats never came out",
                     exp_word_q.size(), exp_beat_q.size());
            err_cnt++;
        end
        // a few idle cycles catch any extra output after the last expected one
        repeat (8) @(posedge clk);
        finish_test("drain", errs_before);

        $display("%0d tests, %0d failed, %0d rx words, %0d tx beats, %0d errors",
                 tests_run, tests_failed, rx_words_seen, tx_beats_seen, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
